// ==== all.f ====
source/multihPkg.sv
source/branchMetric.sv
source/acsUnit.sv
source/survivorPath.sv
source/multihTrellis.sv
tests/clockGen.sv
tests/multihTrellis_props.sv
tests/multihTrellisTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the trellis testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   -f all.f \
   --top-module multihTrellisTb \
   -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
   exit 0
else
   exit 1
fi

// ==== tests/multihTrellisTb.sv ====
module multihTrellisTb;

   timeunit 1ns;
   timeprecision 100ps;

   import multihPkg::*;

   localparam int TRACE_DEPTH = 16;
   // symbols per test phase
   localparam int CLEAN_N = 60;
   localparam int RAND_N = 100;
   localparam int NORM_N = 80;
   localparam int TILT_N = 100;
   localparam int TOTAL_N = CLEAN_N + RAND_N + NORM_N + TILT_N;
   localparam int BIG = 500;

   logic clk;
   logic reset;
   logic symEn;
   corrVec_t corrIn;
   logic signed [TILT_W-1:0] tilt;
   logic bitOut;
   logic bitValid;

   logic [31:0] lfsr = 32'hd56a_4944;

   // reference model state
   int mMetric[NUM_STATES];
   logic [TRACE_DEPTH-1:0] mPath[NUM_STATES];
   logic hPhase;
   int c0[NUM_STATES];
   int c1[NUM_STATES];
   int tiltVal;
   int symCount;
   int bitCount;
   logic expQ[$];
   logic dataQ[$];

   clockGen clockGen_inst (
      .clk   (clk),
      .reset (reset)
   );

   multihTrellis #(
      .TRACE_DEPTH (TRACE_DEPTH)
   ) multihTrellis_inst (
      .clk      (clk),
      .reset    (reset),
      .symEn    (symEn),
      .corrIn   (corrIn),
      .tilt     (tilt),
      .bitOut   (bitOut),
      .bitValid (bitValid)
   );

   // ------------------------------
   // random numbers
   // ------------------------------

   // Fibonacci LFSR with taps 32 22 2 1
   // stepped once per returned bit
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      logic fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   // n-bit two's complement value
   function automatic int randSigned(input int n);
      logic [31:0] v;
      v = randBits(n);
      if (v[n-1]) begin
         return int'(v) - (1 << n);
      end
      return int'(v);
   endfunction

   // ------------------------------
   // checks
   // ------------------------------

   task automatic stopRun(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkBit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
         stopRun("bit mismatch");
      end
   endtask

   task automatic checkCount(input int got, input int exp);
      if (got != exp) begin
         $display("error at %0t: bit count got %0d expected %0d", $time, got, exp);
         stopRun("bit count mismatch");
      end
   endtask

   // ------------------------------
   // reference model
   // ------------------------------

   // one trellis step returning the oldest bit of the best path
   task automatic modelStep(output logic expBit);
      int bm0[NUM_STATES];
      int bm1[NUM_STATES];
      int newM[NUM_STATES];
      logic [TRACE_DEPTH-1:0] newP[NUM_STATES];
      logic norm;
      int src;
      int a;
      int b;
      int w;
      int p0;
      int p1;
      int best;
      // H54 moves filter s to destination s+1
      for (int d = 0; d < NUM_STATES; d++) begin
         src = hPhase ? (d + NUM_STATES - 1) % NUM_STATES : d;
         bm0[d] = c0[src] + tiltVal;
         bm1[d] = c1[src] - tiltVal;
      end
      norm = 1'b0;
      for (int s = 0; s < NUM_STATES; s++) begin
         if (mMetric[s] >= 2 ** (METRIC_W - 1)) norm = 1'b1;
      end
      for (int d = 0; d < NUM_STATES; d++) begin
         p0 = (2 * d) % NUM_STATES;
         p1 = (2 * d + 1) % NUM_STATES;
         a = mMetric[p0] + bm0[d];
         b = mMetric[p1] + bm1[d];
         // metric range is 0 .. 2^METRIC_W-1
         a = (a < 0) ? 0 : (a > 2 ** METRIC_W - 1) ? 2 ** METRIC_W - 1 : a;
         b = (b < 0) ? 0 : (b > 2 ** METRIC_W - 1) ? 2 ** METRIC_W - 1 : b;
         w = (b > a) ? b : a;
         if (norm) begin
            w = (w >= 2 ** (METRIC_W - 1)) ? w - 2 ** (METRIC_W - 1) : 0;
         end
         newM[d] = w;
         if (b > a) begin
            newP[d] = {mPath[p1][TRACE_DEPTH-2:0], 1'b1};
         end else begin
            newP[d] = {mPath[p0][TRACE_DEPTH-2:0], 1'b0};
         end
      end
      best = 0;
      for (int s = 0; s < NUM_STATES; s++) begin
         mMetric[s] = newM[s];
         mPath[s] = newP[s];
         if (newM[s] > newM[best]) best = s;
      end
      expBit = newP[best][TRACE_DEPTH-1];
      hPhase = ~hPhase;
   endtask

   // ------------------------------
   // stimulus
   // ------------------------------

   // one strobe and idle cycles up to the next slot
   task automatic sendSymbol(input int gap, input logic useData);
      logic expBit;
      for (int s = 0; s < NUM_STATES; s++) begin
         corrIn.bit0[s] = corr_t'(c0[s]);
         corrIn.bit1[s] = corr_t'(c1[s]);
      end
      modelStep(expBit);
      symCount++;
      if (useData) begin
         // data bit from TRACE_DEPTH-1 symbols ago
         if (dataQ.size() == TRACE_DEPTH) expQ.push_back(dataQ.pop_front());
      end else if (symCount >= TRACE_DEPTH) begin
         expQ.push_back(expBit);
      end
      symEn = 1'b1;
      @(negedge clk);
      symEn = 1'b0;
      repeat (gap - 1) @(negedge clk);
   endtask

   task automatic randomCorr(input int n);
      for (int s = 0; s < NUM_STATES; s++) begin
         c0[s] = randSigned(n);
         c1[s] = randSigned(n);
      end
   endtask

   // ------------------------------
   // output monitor
   // ------------------------------

   always @(negedge clk) begin
      if (reset) begin
         if (bitValid === 1'b1) stopRun("bitValid went high during reset");
      end else if (bitValid) begin
         if (expQ.size() == 0) begin
            stopRun("bitValid went high with no bit expected");
         end else begin
            checkBit(bitOut, expQ.pop_front(), "bitOut");
            bitCount++;
         end
      end
   end

   // watchdog
   initial begin
      repeat (TOTAL_N * 6 + 100) @(posedge clk);
      $display("watchdog expired before all symbols were decoded");
      $display("Test failed");
      $fatal(1, "timeout");
   end

   // ------------------------------
   // test sequence
   // ------------------------------

   initial begin
      int st;
      int nxt;
      int f;
      logic tb;
      symEn = 1'b0;
      corrIn = '0;
      tilt = '0;
      tiltVal = 0;
      hPhase = 1'b0;
      symCount = 0;
      bitCount = 0;
      for (int s = 0; s < NUM_STATES; s++) begin
         mMetric[s] = 0;
         mPath[s] = '0;
      end
      @(negedge clk);
      while (reset) @(negedge clk);
      repeat (2) @(negedge clk);

      // clean channel with the true path starting in state 0
      st = 0;
      for (int k = 0; k < CLEAN_N; k++) begin
         // from st only (st/2)+{0,2} are reachable
         nxt = (st >> 1) + 2 * int'(randBits(1));
         tb = st[0];
         dataQ.push_back(tb);
         randomCorr(5);
         f = hPhase ? (nxt + NUM_STATES - 1) % NUM_STATES : nxt;
         if (tb) c1[f] = BIG;
         else c0[f] = BIG;
         sendSymbol(4, 1'b1);
         st = nxt;
      end

      // random correlations and spacing
      for (int k = 0; k < RAND_N; k++) begin
         randomCorr(12);
         sendSymbol(4 + int'(randBits(3)) % 6, 1'b0);
      end

      // large positive values force normalisation
      for (int k = 0; k < NORM_N; k++) begin
         for (int s = 0; s < NUM_STATES; s++) begin
            c0[s] = 1500 + int'(randBits(9));
            c1[s] = 1500 + int'(randBits(9));
         end
         sendSymbol(4, 1'b0);
      end

      // nonzero tilt over both h phases
      tiltVal = -7;
      tilt = TILT_W'(tiltVal);
      for (int k = 0; k < TILT_N; k++) begin
         randomCorr(12);
         sendSymbol(4, 1'b0);
      end

      repeat (4) @(negedge clk);
      checkCount(bitCount, TOTAL_N - TRACE_DEPTH + 1);
      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== tests/multihTrellis_props.sv ====
module multihTrellis_props #(
   parameter int TRACE_DEPTH = 16
) (
   input logic clk,
   input logic reset,
   input logic symEn,
   input logic bitValid
);

   timeunit 1ns;
   timeprecision 100ps;

   // symbols seen since reset, saturating
   int symCount;

   always_ff @(posedge clk) begin
      if (reset) begin
         symCount <= 0;
      end else if (symEn && symCount < TRACE_DEPTH) begin
         symCount <= symCount + 1;
      end
   end

   // no output bit before the paths are full
   noEarlyBit: assert property (@(posedge clk) disable iff (reset)
      bitValid |-> symCount >= TRACE_DEPTH)
      else $error("bitValid before warm-up ended");

   // fixed two cycle latency once warmed up
   bitLatency: assert property (@(posedge clk) disable iff (reset)
      (symEn && symCount >= TRACE_DEPTH - 1) |-> ##2 bitValid)
      else $error("bitValid missing two cycles after symEn");

   // strobe is a single cycle
   singleStrobe: assert property (@(posedge clk) disable iff (reset)
      bitValid |=> !bitValid)
      else $error("bitValid high two cycles in a row");

endmodule

bind multihTrellis multihTrellis_props #(
   .TRACE_DEPTH (TRACE_DEPTH)
) props_inst (
   .clk      (clk),
   .reset    (reset),
   .symEn    (symEn),
   .bitValid (bitValid)
);

// ==== tests/clockGen.sv ====
module clockGen (
   output logic clk,
   output logic reset
);

   timeunit 1ns;
   timeprecision 100ps;

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // reset held for 10 cycles
   initial begin
      reset = 1'b1;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

// ==== source/multihTrellis.sv ====
module multihTrellis #(
   parameter int TRACE_DEPTH = 16
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                symEn,
   input  multihPkg::corrVec_t                 corrIn,
   input  logic signed [multihPkg::TILT_W-1:0] tilt,
   output logic                                bitOut,
   output logic                                bitValid
);

   import multihPkg::*;

   // branch metrics by destination state
   branchVec_t bmVec;
   logic bmValid;

   // ACS results
   metricVec_t metricVec;
   decision_t decVec;
   // shared normalisation from the survivor block
   logic normalize;

   // ------------------------------
   // branch metrics
   // ------------------------------

   branchMetric branchMetric_inst (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .corrIn  (corrIn),
      .tilt    (tilt),
      .bmVec   (bmVec),
      .bmValid (bmValid)
   );

   // ------------------------------
   // one ACS per state
   // ------------------------------

   // state s is entered from 2s (bit 0) and 2s+1 (bit 1)
   for (genvar s = 0; s < NUM_STATES; s++) begin : gAcs
      acsUnit acsUnit_inst (
         .clk         (clk),
         .reset       (reset),
         .bmValid     (bmValid),
         .branch      (bmVec[s]),
         .pred0Metric (metricVec[(2 * s) % NUM_STATES]),
         .pred1Metric (metricVec[(2 * s + 1) % NUM_STATES]),
         .normalize   (normalize),
         .metric      (metricVec[s]),
         .decision    (decVec[s])
      );
   end

   // ------------------------------
   // survivor memory
   // ------------------------------

   survivorPath #(
      .TRACE_DEPTH (TRACE_DEPTH)
   ) survivorPath_inst (
      .clk       (clk),
      .reset     (reset),
      .bmValid   (bmValid),
      .metricVec (metricVec),
      .decVec    (decVec),
      .normalize (normalize),
      .bitOut    (bitOut),
      .bitValid  (bitValid)
   );

endmodule

// ==== source/survivorPath.sv ====
module survivorPath #(
   parameter int TRACE_DEPTH = 16
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  bmValid,
   input  multihPkg::metricVec_t metricVec,
   input  multihPkg::decision_t  decVec,
   output logic                  normalize,
   output logic                  bitOut,
   output logic                  bitValid
);

   import multihPkg::*;

   // counts up to TRACE_DEPTH-1 and holds
   localparam int CNT_W = $clog2(TRACE_DEPTH + 1);

   // decisions and new metrics are valid in this cycle
   logic decValid;
   logic [CNT_W-1:0] warmCount;

   // newest bit at index 0, oldest at TRACE_DEPTH-1
   logic [NUM_STATES-1:0][TRACE_DEPTH-1:0] pathReg;
   logic [NUM_STATES-1:0][TRACE_DEPTH-1:0] pathNext;

   logic [STATE_W-1:0] bestState;
   metric_t bestMetric;

   // ------------------------------
   // normalisation request
   // ------------------------------

   // any metric in the upper half pulls all of them down
   always_comb begin
      normalize = 1'b0;
      for (int s = 0; s < NUM_STATES; s++) begin
         normalize = normalize | metricVec[s][METRIC_W-1];
      end
   end

   // ------------------------------
   // register exchange
   // ------------------------------

   // predecessors of s are 2s and 2s+1, the input bit names the winner
   always_comb begin
      for (int s = 0; s < NUM_STATES; s++) begin
         if (decVec[s]) begin
            pathNext[s] = {pathReg[(2 * s + 1) % NUM_STATES][TRACE_DEPTH-2:0], 1'b1};
         end else begin
            pathNext[s] = {pathReg[(2 * s) % NUM_STATES][TRACE_DEPTH-2:0], 1'b0};
         end
      end
   end

   // best state, lowest index on a tie
   always_comb begin
      bestState  = '0;
      bestMetric = metricVec[0];
      for (int s = 1; s < NUM_STATES; s++) begin
         if (metricVec[s] > bestMetric) begin
            bestState  = STATE_W'(s);
            bestMetric = metricVec[s];
         end
      end
   end

   // ------------------------------
   // registers
   // ------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         decValid  <= 1'b0;
         warmCount <= '0;
         pathReg   <= '0;
      end else begin
         decValid <= bmValid;
         if (decValid) begin
            pathReg <= pathNext;
            // warm-up stops once the paths are full
            if (warmCount != CNT_W'(TRACE_DEPTH - 1)) begin
               warmCount <= warmCount + 1'b1;
            end
         end
      end
   end

   // oldest bit of the best path, in the update cycle
   assign bitOut   = pathNext[bestState][TRACE_DEPTH-1];
   assign bitValid = decValid & (warmCount == CNT_W'(TRACE_DEPTH - 1));

endmodule

// ==== source/acsUnit.sv ====
module acsUnit (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            bmValid,
   input  multihPkg::branchPair_t          branch,
   input  logic [multihPkg::METRIC_W-1:0]  pred0Metric,
   input  logic [multihPkg::METRIC_W-1:0]  pred1Metric,
   input  logic                            normalize,
   output logic [multihPkg::METRIC_W-1:0]  metric,
   output logic                            decision
);

   import multihPkg::*;

   // wide enough for any metric plus any branch
   localparam int SUM_W = CORR_W + 2;
   localparam logic signed [SUM_W-1:0] MAX_SUM = 2**METRIC_W - 1;
   // amount removed by one normalisation step
   localparam metric_t HALF = metric_t'(1) << (METRIC_W - 1);

   logic signed [SUM_W-1:0] sum0;
   logic signed [SUM_W-1:0] sum1;
   metric_t cand0;
   metric_t cand1;
   metric_t winner;
   metric_t nextMetric;
   logic pick1;

   // clamp into the metric range at both ends
   function automatic metric_t clampSum(input logic signed [SUM_W-1:0] sum);
      metric_t result;
      if (sum < 0) begin
         result = '0;
      end else if (sum > MAX_SUM) begin
         result = '1;
      end else begin
         result = sum[METRIC_W-1:0];
      end
      return result;
   endfunction

   // ------------------------------
   // add, compare, select
   // ------------------------------

   always_comb begin
      // metrics are unsigned, zero extend before the signed add
      sum0  = $signed({1'b0, pred0Metric}) + branch.bit0;
      sum1  = $signed({1'b0, pred1Metric}) + branch.bit1;
      cand0 = clampSum(sum0);
      cand1 = clampSum(sum1);
      // tie keeps predecessor 0
      pick1  = (cand1 > cand0);
      winner = pick1 ? cand1 : cand0;
      // shared step, floor at zero for states far below the leader
      if (normalize) begin
         nextMetric = (winner >= HALF) ? winner - HALF : '0;
      end else begin
         nextMetric = winner;
      end
   end

   // accumulated metric
   always_ff @(posedge clk) begin
      if (reset) begin
         metric <= '0;
      end else if (bmValid) begin
         metric <= nextMetric;
      end
   end

   // survivor choice for the path memory
   always_ff @(posedge clk) begin
      if (bmValid) begin
         decision <= pick1;
      end
   end

endmodule

// ==== source/branchMetric.sv ====
module branchMetric (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                symEn,
   input  multihPkg::corrVec_t                 corrIn,
   input  logic signed [multihPkg::TILT_W-1:0] tilt,
   output multihPkg::branchVec_t               bmVec,
   output logic                                bmValid
);

   import multihPkg::*;

   // index used for the symbol now at the input
   hIndex_t hIndex;

   // correlations with tilt applied, still in filter order
   branchPair_t [NUM_STATES-1:0] biased;
   // after the h-dependent rotation
   branchVec_t bmNext;

   // ------------------------------
   // tilt bias
   // ------------------------------

   // tilt pushes bit 0 up and bit 1 down by the same amount
   always_comb begin
      for (int s = 0; s < NUM_STATES; s++) begin
         // sign extension to CORR_W+1 from the signed context
         biased[s].bit0 = corrIn.bit0[s] + tilt;
         biased[s].bit1 = corrIn.bit1[s] - tilt;
      end
   end

   // ------------------------------
   // state rotation
   // ------------------------------

   // under H54 the pair of filter s lands on destination s+1
   always_comb begin
      for (int s = 0; s < NUM_STATES; s++) begin
         if (hIndex == H54) begin
            bmNext[s] = biased[(s + NUM_STATES - 1) % NUM_STATES];
         end else begin
            bmNext[s] = biased[s];
         end
      end
   end

   // ------------------------------
   // registers
   // ------------------------------

   // strobe and h phase
   always_ff @(posedge clk) begin
      if (reset) begin
         hIndex  <= H45;
         bmValid <= 1'b0;
      end else begin
         bmValid <= symEn;
         // alternate index every symbol
         if (symEn) begin
            hIndex <= (hIndex == H45) ? H54 : H45;
         end
      end
   end

   // metrics held until the next strobe
   always_ff @(posedge clk) begin
      if (symEn) begin
         bmVec <= bmNext;
      end
   end

endmodule

// ==== source/multihPkg.sv ====
package multihPkg;

   // ------------------------------
   // trellis size and datapath widths
   // ------------------------------

   // number of trellis states
   localparam int NUM_STATES = 4;
   // bits needed to name a state
   localparam int STATE_W = $clog2(NUM_STATES);
   // signed matched-filter correlation
   localparam int CORR_W = 18;
   // unsigned accumulated path metric
   localparam int METRIC_W = 12;
   // signed tilt bias
   localparam int TILT_W = 5;

   // ------------------------------
   // scalar types
   // ------------------------------

   // modulation index of the current symbol, h = 4/16 or 5/16
   typedef enum logic {
      H45 = 1'b0,
      H54 = 1'b1
   } hIndex_t;

   // named signed types keep packed array elements signed
   typedef logic signed [CORR_W-1:0] corr_t;
   // one extra bit so the tilt bias cannot overflow
   typedef logic signed [CORR_W:0] bm_t;
   typedef logic [METRIC_W-1:0] metric_t;

   // ------------------------------
   // bundles
   // ------------------------------

   // filter bank output, one value per state and hypothesised bit
   typedef struct packed {
      corr_t [NUM_STATES-1:0] bit1;
      corr_t [NUM_STATES-1:0] bit0;
   } corrVec_t;

   // branch metrics into one destination state
   typedef struct packed {
      bm_t bit1;
      bm_t bit0;
   } branchPair_t;

   // indexed by destination state
   typedef branchPair_t [NUM_STATES-1:0] branchVec_t;

   typedef metric_t [NUM_STATES-1:0] metricVec_t;

   // one bit per state, set when the bit-1 predecessor survived
   typedef logic [NUM_STATES-1:0] decision_t;

endpackage
